// ==== build.f ====
+incdir+.
exu_pkg.sv
exu_fu_res_if.sv
exu_alu.sv
exu_lsu.sv
exu_divider.sv
exu_func_units.sv
exu_func_units_asserts.sv
tb_exu_func_units.sv

// ==== Bender.yml ====
package:
  name: exu_func_units

sources:
  - include_dirs:
      - .
    files:
      - exu_pkg.sv
      - exu_fu_res_if.sv
      - exu_alu.sv
      - exu_lsu.sv
      - exu_divider.sv
      - exu_func_units.sv
  - target: test
    include_dirs:
      - .
    files:
      - exu_func_units_asserts.sv
      - tb_exu_func_units.sv

// ==== tb_exu_func_units.sv ====
// table driven testbench for the execution unit group with an icb memory model
// compile with build.f, bound assertions watch icb and divider timing alongside
`timescale 1ns/10ps
`include "exu_settings.svh"

module tb_exu_func_units;
	import exu_pkg::*;

	localparam int tw = `EXU_TID_WIDTH;

	typedef struct {
		string name;
		int unit; // 0 alu, 1 lsu, 2 divider, same as the fu_res_vld bit
		alu_op_e op;
		ls_type_e ty;
		logic sel; // alu use_res, lsu store, divider remainder
		logic [31:0] a; // op1, access address or dividend
		logic [31:0] b; // op2, store data or divisor
		logic [31:0] exp_data;
		fu_err_e exp_err;
		logic [3:0] exp_mask; // checked on good stores only
	} test_t;

	logic aclk;
	logic reset;
	alu_op_e s_alu_op_mode;
	logic [31:0] s_alu_op1;
	logic [31:0] s_alu_op2;
	logic [tw-1:0] s_alu_tid;
	logic s_alu_use_res;
	logic s_alu_valid;
	logic m_alu_brc_cond_res;
	logic s_lsu_ls_sel;
	ls_type_e s_lsu_ls_type;
	logic [31:0] s_lsu_ls_din;
	logic [tw-1:0] s_lsu_inst_id;
	logic s_lsu_valid;
	logic s_lsu_ready;
	logic signed [32:0] s_div_op_a;
	logic signed [32:0] s_div_op_b;
	logic s_div_rem_sel;
	logic [tw-1:0] s_div_inst_id;
	logic s_div_valid;
	logic s_div_ready;
	logic [2:0] fu_res_vld;
	logic [3*tw-1:0] fu_res_tid;
	logic [3*32-1:0] fu_res_data;
	logic [3*3-1:0] fu_res_err;
	logic [31:0] m_icb_cmd_addr;
	logic m_icb_cmd_read;
	logic [31:0] m_icb_cmd_wdata;
	logic [3:0] m_icb_cmd_wmask;
	logic m_icb_cmd_valid;
	logic m_icb_cmd_ready;
	logic [31:0] m_icb_rsp_rdata;
	logic m_icb_rsp_err;
	logic m_icb_rsp_valid;
	logic m_icb_rsp_ready;
	logic dbus_timeout;

	logic [31:0] mem [0:63]; // mirrored every 256 bytes
	logic [3:0] last_wmask; // mask of the latest write into mem
	int cmd_count;
	test_t tests[$];
	int num_tests = 0;
	int errors;
	int checks;
	logic timeout_seen; // set once an access to the silent range ran

	exu_func_units uut (.*);

	initial begin
		aclk = 1'b0;
		forever #50 aclk = ~aclk;
	end

	task automatic tick();
		@(posedge aclk);
		#10;
	endtask

	task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_err(input string name, input fu_err_e exp, input fu_err_e act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL %s err: expected %s, actual %s (%0d)", name, exp.name(),
				act.name(), act);
		end
	endtask

	task automatic check_tid(input string name, input logic [tw-1:0] exp,
		input logic [tw-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL %s tid: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_mask(input string name, input logic [3:0] exp, input logic [3:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL %s wmask: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_result(input test_t t, input int u, input logic [tw-1:0] tid);
		check_data(t.name, t.exp_data, fu_res_data[32*u +: 32]);
		check_err(t.name, t.exp_err, fu_err_e'(fu_res_err[3*u +: 3]));
		check_tid(t.name, tid, fu_res_tid[tw*u +: tw]);
	endtask

	task automatic run_alu(input test_t t, input logic [tw-1:0] tid);
		s_alu_op_mode = t.op;
		s_alu_op1 = t.a;
		s_alu_op2 = t.b;
		s_alu_tid = tid;
		s_alu_use_res = t.sel;
		s_alu_valid = 1'b1;
		#5; // combinational, settles well inside the cycle
		check_data({t.name, " vld"}, {31'd0, t.sel}, {31'd0, fu_res_vld[0]});
		check_data({t.name, " brc"}, (t.op >= alu_op_beq) ? t.exp_data : 32'd0,
			{31'd0, m_alu_brc_cond_res});
		if (t.sel)
			check_result(t, 0, tid);
		tick();
		s_alu_valid = 1'b0;
		s_alu_use_res = 1'b0;
	endtask

	task automatic run_lsu(input test_t t, input logic [tw-1:0] tid);
		int c0;
		s_alu_op1 = t.a; // access address comes from the alu adder
		s_alu_op2 = 32'd0;
		s_lsu_ls_sel = t.sel;
		s_lsu_ls_type = t.ty;
		s_lsu_ls_din = t.b;
		s_lsu_inst_id = tid;
		s_lsu_valid = 1'b1;
		last_wmask = 4'h0;
		c0 = cmd_count;
		while (!s_lsu_ready)
			tick();
		tick(); // request taken on this edge
		s_lsu_valid = 1'b0;
		while (!fu_res_vld[1])
			tick();
		check_result(t, 1, tid);
		if (t.a >= 32'h2000)
			timeout_seen = 1'b1;
		check_data({t.name, " timeout"}, {31'd0, timeout_seen}, {31'd0, dbus_timeout});
		if (t.exp_err == err_rd_unaligned || t.exp_err == err_wt_unaligned)
			check_data({t.name, " icb cmds"}, 32'(c0), 32'(cmd_count)); // bus stays quiet
		if (t.sel && t.exp_err == err_normal)
			check_mask(t.name, t.exp_mask, last_wmask);
	endtask

	task automatic run_div(input test_t t, input logic [tw-1:0] tid);
		s_div_op_a = {t.a[31], t.a}; // signed operands
		s_div_op_b = {t.b[31], t.b};
		s_div_rem_sel = t.sel;
		s_div_inst_id = tid;
		s_div_valid = 1'b1;
		while (!s_div_ready)
			tick();
		tick();
		s_div_valid = 1'b0;
		// alu keeps working while the divide runs
		for (int k = 0; k <= `EXU_DIV_ITER; k++) begin
			s_alu_op_mode = alu_op_add;
			s_alu_op1 = k;
			s_alu_op2 = 32'h100;
			s_alu_tid = tw'(k);
			s_alu_use_res = 1'b1;
			s_alu_valid = 1'b1;
			#5;
			check_data({t.name, " overlap vld"}, 32'd1, {31'd0, fu_res_vld[0]});
			check_data({t.name, " overlap alu"}, 32'h100 + k, fu_res_data[31:0]);
			if (fu_res_vld[2]) begin
				errors++;
				$display("divider test %s: result arrived early, %0d cycles after accept",
					t.name, k);
			end
			tick();
		end
		s_alu_valid = 1'b0;
		s_alu_use_res = 1'b0;
		if (!fu_res_vld[2]) begin
			errors++;
			$display("divider test %s: no result %0d cycles after accept", t.name,
				`EXU_DIV_ITER + 1);
		end else begin
			check_result(t, 2, tid);
		end
	endtask

	task automatic add_alu(input string name, input alu_op_e op, input logic use_res,
		input logic [31:0] a, input logic [31:0] b, input logic [31:0] exp);
		tests.push_back('{name, 0, op, ls_word, use_res, a, b, exp, err_normal, 4'h0});
	endtask

	task automatic add_lsu(input string name, input ls_type_e ty, input logic store,
		input logic [31:0] addr, input logic [31:0] din, input logic [31:0] exp,
		input fu_err_e err, input logic [3:0] mask);
		tests.push_back('{name, 1, alu_op_add, ty, store, addr, din, exp, err, mask});
	endtask

	task automatic add_div(input string name, input logic rem, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] exp);
		tests.push_back('{name, 2, alu_op_add, ls_word, rem, a, b, exp, err_normal, 4'h0});
	endtask

	task automatic build_table();
		// alu, rv32i results, the last one with use_res low
		add_alu("add", alu_op_add, 1, 32'h7, 32'hfffffffd, 32'h4);
		add_alu("sub", alu_op_sub, 1, 32'h5, 32'h7, 32'hfffffffe);
		add_alu("sll", alu_op_sll, 1, 32'h1, 32'h24, 32'h10);
		add_alu("slt", alu_op_slt, 1, 32'hffffffff, 32'h1, 32'h1);
		add_alu("sltu", alu_op_sltu, 1, 32'hffffffff, 32'h1, 32'h0);
		add_alu("xor", alu_op_xor, 1, 32'hf0f0f0f0, 32'hff00ff00, 32'h0ff00ff0);
		add_alu("srl", alu_op_srl, 1, 32'h80000000, 32'd31, 32'h1);
		add_alu("sra", alu_op_sra, 1, 32'h80000000, 32'd4, 32'hf8000000);
		add_alu("or", alu_op_or, 1, 32'h12340000, 32'h5678, 32'h12345678);
		add_alu("and", alu_op_and, 1, 32'h12345678, 32'h0f0f0f0f, 32'h02040608);
		add_alu("beq", alu_op_beq, 1, 32'h5, 32'h5, 32'h1);
		add_alu("bne", alu_op_bne, 1, 32'h5, 32'h5, 32'h0);
		add_alu("blt", alu_op_blt, 1, 32'hfffffff0, 32'h1, 32'h1);
		add_alu("bge", alu_op_bge, 1, 32'hfffffff0, 32'h1, 32'h0);
		add_alu("bltu", alu_op_bltu, 1, 32'hfffffff0, 32'h1, 32'h0);
		add_alu("bgeu", alu_op_bgeu, 1, 32'hfffffff0, 32'h1, 32'h1);
		add_alu("add no use", alu_op_add, 0, 32'h1, 32'h1, 32'h2);
		// lsu, a good store returns zero data
		add_lsu("sw", ls_word, 1, 32'h100, 32'h8badf00d, 32'h0, err_normal, 4'hf);
		add_lsu("lw", ls_word, 0, 32'h100, 32'h0, 32'h8badf00d, err_normal, 4'h0);
		add_lsu("sh", ls_half, 1, 32'h106, 32'h12348001, 32'h0, err_normal, 4'hc);
		add_lsu("lh", ls_half, 0, 32'h106, 32'h0, 32'hffff8001, err_normal, 4'h0);
		add_lsu("lhu", ls_half_u, 0, 32'h106, 32'h0, 32'h8001, err_normal, 4'h0);
		add_lsu("sb hi", ls_byte, 1, 32'h10b, 32'hf0, 32'h0, err_normal, 4'h8);
		add_lsu("lb", ls_byte, 0, 32'h10b, 32'h0, 32'hfffffff0, err_normal, 4'h0);
		add_lsu("lbu", ls_byte_u, 0, 32'h10b, 32'h0, 32'hf0, err_normal, 4'h0);
		add_lsu("sb lane1", ls_byte, 1, 32'h101, 32'h7e, 32'h0, err_normal, 4'h2);
		add_lsu("lw merged", ls_word, 0, 32'h100, 32'h0, 32'h8bad7e0d, err_normal, 4'h0);
		add_lsu("lb lane1", ls_byte, 0, 32'h101, 32'h0, 32'h7e, err_normal, 4'h0);
		add_lsu("lh odd", ls_half, 0, 32'h103, 32'h0, 32'h103, err_rd_unaligned, 4'h0);
		add_lsu("sw odd", ls_word, 1, 32'h102, 32'h1, 32'h102, err_wt_unaligned, 4'h0);
		add_lsu("lw odd", ls_word, 0, 32'h101, 32'h0, 32'h101, err_rd_unaligned, 4'h0);
		add_lsu("lw buserr", ls_word, 0, 32'h1000, 32'h0, 32'h1000, err_rd_failed, 4'h0);
		add_lsu("sw buserr", ls_word, 1, 32'h1004, 32'h1, 32'h1004, err_wt_failed, 4'h0);
		add_lsu("lw silent", ls_word, 0, 32'h2000, 32'h0, 32'h2000, err_rd_failed, 4'h0);
		add_lsu("sw silent", ls_word, 1, 32'h2008, 32'h1, 32'h2008, err_wt_failed, 4'h0);
		add_lsu("lbu after", ls_byte_u, 0, 32'h10b, 32'h0, 32'hf0, err_normal, 4'h0);
		// divider, signed with truncation toward zero
		add_div("div", 0, 32'd100, 32'd7, 32'he);
		add_div("rem", 1, 32'd100, 32'd7, 32'h2);
		add_div("div -a", 0, 32'hffffff9c, 32'd7, 32'hfffffff2);
		add_div("rem -a", 1, 32'hffffff9c, 32'd7, 32'hfffffffe);
		add_div("div -b", 0, 32'd100, 32'hfffffff9, 32'hfffffff2);
		add_div("rem -b", 1, 32'd100, 32'hfffffff9, 32'h2);
		add_div("div -a -b", 0, 32'hffffff9c, 32'hfffffff9, 32'he);
		add_div("rem -a -b", 1, 32'hffffff9c, 32'hfffffff9, 32'hfffffffe);
		add_div("div by 0", 0, 32'd1234, 32'd0, 32'hffffffff);
		add_div("rem by 0", 1, 32'd1234, 32'd0, 32'h4d2);
		add_div("rem -a by 0", 1, 32'hfffffffb, 32'd0, 32'hfffffffb);
		add_div("div min", 0, 32'h80000000, 32'hffffffff, 32'h80000000);
		add_div("rem min", 1, 32'h80000000, 32'hffffffff, 32'h0);
	endtask

	// icb slave, every second command waits a cycle for ready, random response delay
	initial begin : icb_memory
		logic [31:0] addr;
		logic rd;
		logic [31:0] wdata;
		logic [3:0] wmask;
		int delay;
		void'($urandom(83822));
		for (int i = 0; i < 64; i++)
			mem[i] = {16'hc0de, 16'(i * 4)}; // word carries its own byte address
		m_icb_cmd_ready = 1'b1;
		m_icb_rsp_valid = 1'b0;
		m_icb_rsp_err = 1'b0;
		m_icb_rsp_rdata = 32'h0;
		cmd_count = 0;
		last_wmask = 4'h0;
		forever begin
			tick();
			if (m_icb_cmd_valid) begin
				cmd_count++;
				if (cmd_count % 2 == 0) begin
					m_icb_cmd_ready = 1'b0; // slave busy, command must stay put
					tick();
					m_icb_cmd_ready = 1'b1;
				end
				addr = m_icb_cmd_addr;
				rd = m_icb_cmd_read;
				wdata = m_icb_cmd_wdata;
				wmask = m_icb_cmd_wmask;
				tick(); // command taken on this edge
				if (addr < 32'h2000) begin // above that no response at all
					delay = $urandom_range(3);
					repeat (delay)
						tick();
					m_icb_rsp_err = addr >= 32'h1000;
					m_icb_rsp_rdata = 32'h0;
					if (addr < 32'h1000 && rd) begin
						m_icb_rsp_rdata = mem[addr[7:2]];
					end else if (addr < 32'h1000) begin
						for (int b = 0; b < 4; b++)
							if (wmask[b])
								mem[addr[7:2]][8*b +: 8] = wdata[8*b +: 8];
						last_wmask = wmask;
					end
					m_icb_rsp_valid = 1'b1;
					checks++;
					if (m_icb_rsp_ready !== 1'b1) begin
						errors++;
						$display("icb response for %h offered while rsp_ready was low", addr);
					end
					tick();
					m_icb_rsp_valid = 1'b0;
					m_icb_rsp_err = 1'b0;
				end
			end
		end
	end

	initial begin : watchdog
		wait (num_tests > 0);
		repeat (num_tests * 60)
			@(posedge aclk);
		$display("watchdog expired, run did not finish within %0d cycles", num_tests * 60);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin : main
		test_t t;
		int e0;
		reset = 1'b1;
		s_alu_op_mode = alu_op_add;
		s_alu_op1 = 32'h0;
		s_alu_op2 = 32'h0;
		s_alu_tid = '0;
		s_alu_use_res = 1'b0;
		s_alu_valid = 1'b0;
		s_lsu_ls_sel = 1'b0;
		s_lsu_ls_type = ls_word;
		s_lsu_ls_din = 32'h0;
		s_lsu_inst_id = '0;
		s_lsu_valid = 1'b0;
		s_div_op_a = '0;
		s_div_op_b = '0;
		s_div_rem_sel = 1'b0;
		s_div_inst_id = '0;
		s_div_valid = 1'b0;
		errors = 0;
		checks = 0;
		timeout_seen = 1'b0;
		build_table();
		num_tests = tests.size();
		repeat (8)
			@(posedge aclk);
		#10;
		reset = 1'b0;
		foreach (tests[i]) begin
			t = tests[i];
			e0 = errors;
			case (t.unit)
				0: run_alu(t, tw'(32 + i));
				1: run_lsu(t, tw'(32 + i));
				default: run_div(t, tw'(32 + i));
			endcase
			if (errors == e0)
				$display("test %s: ok", t.name);
			else
				$display("test %s: %0d mismatches", t.name, errors - e0);
		end
		$display("%0d tests, %0d checks, %0d errors", num_tests, checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== exu_func_units_asserts.sv ====
// concurrent checks on the execution unit top level ports
// bound into every exu_func_units instance by the bind at the end of this file
`timescale 1ns/10ps
`include "exu_settings.svh"

module exu_func_units_asserts (
	input logic aclk,
	input logic reset,
	input logic [31:0] m_icb_cmd_addr,
	input logic m_icb_cmd_read,
	input logic [31:0] m_icb_cmd_wdata,
	input logic [3:0] m_icb_cmd_wmask,
	input logic m_icb_cmd_valid,
	input logic m_icb_cmd_ready,
	input logic dbus_timeout,
	input logic s_div_valid,
	input logic s_div_ready,
	input logic [2:0] fu_res_vld
);
	localparam int div_lat = `EXU_DIV_ITER + 1; // accept edge to result pulse

	// command fields frozen until the slave takes them
	cmd_hold: assert property (@(posedge aclk) disable iff (reset)
		m_icb_cmd_valid && !m_icb_cmd_ready |=> m_icb_cmd_valid
		&& $stable({m_icb_cmd_addr, m_icb_cmd_read, m_icb_cmd_wdata, m_icb_cmd_wmask}))
		else $error("icb command dropped or changed before ready");

	timeout_sticky: assert property (@(posedge aclk) disable iff (reset)
		$fell(dbus_timeout) |-> $past(reset)) // only reset clears it
		else $error("dbus_timeout fell without reset");

	div_latency: assert property (@(posedge aclk) disable iff (reset)
		s_div_valid && s_div_ready |=> !fu_res_vld[2] [*div_lat] ##1 fu_res_vld[2])
		else $error("divider result not %0d cycles after accept", div_lat);

endmodule

bind exu_func_units exu_func_units_asserts asserts_u (
	.aclk(aclk), .reset(reset),
	.m_icb_cmd_addr(m_icb_cmd_addr), .m_icb_cmd_read(m_icb_cmd_read),
	.m_icb_cmd_wdata(m_icb_cmd_wdata), .m_icb_cmd_wmask(m_icb_cmd_wmask),
	.m_icb_cmd_valid(m_icb_cmd_valid), .m_icb_cmd_ready(m_icb_cmd_ready),
	.dbus_timeout(dbus_timeout), .s_div_valid(s_div_valid), .s_div_ready(s_div_ready),
	.fu_res_vld(fu_res_vld)
);

// ==== exu_func_units.sv ====
// execution unit group top with alu, lsu and divider
// results leave on flat buses, bit 0 alu, bit 1 lsu, bit 2 divider
`timescale 1ns/10ps
`include "exu_settings.svh"

module exu_func_units (
	input logic aclk,
	input logic reset,
	input exu_pkg::alu_op_e s_alu_op_mode,
	input logic [31:0] s_alu_op1,
	input logic [31:0] s_alu_op2,
	input logic [`EXU_TID_WIDTH-1:0] s_alu_tid,
	input logic s_alu_use_res,
	input logic s_alu_valid,
	output logic m_alu_brc_cond_res,
	input logic s_lsu_ls_sel,
	input exu_pkg::ls_type_e s_lsu_ls_type,
	input logic [31:0] s_lsu_ls_din,
	input logic [`EXU_TID_WIDTH-1:0] s_lsu_inst_id,
	input logic s_lsu_valid,
	output logic s_lsu_ready,
	input logic signed [32:0] s_div_op_a,
	input logic signed [32:0] s_div_op_b,
	input logic s_div_rem_sel,
	input logic [`EXU_TID_WIDTH-1:0] s_div_inst_id,
	input logic s_div_valid,
	output logic s_div_ready,
	output logic [2:0] fu_res_vld,
	output logic [3*`EXU_TID_WIDTH-1:0] fu_res_tid,
	output logic [3*32-1:0] fu_res_data,
	output logic [3*3-1:0] fu_res_err,
	output logic [31:0] m_icb_cmd_addr,
	output logic m_icb_cmd_read,
	output logic [31:0] m_icb_cmd_wdata,
	output logic [3:0] m_icb_cmd_wmask,
	output logic m_icb_cmd_valid,
	input logic m_icb_cmd_ready,
	input logic [31:0] m_icb_rsp_rdata,
	input logic m_icb_rsp_err,
	input logic m_icb_rsp_valid,
	output logic m_icb_rsp_ready,
	output logic dbus_timeout // sticky data bus timeout
);

	logic [31:0] alu_ls_addr; // lsu address comes from the alu adder

	exu_fu_res_if alu_res();
	exu_fu_res_if lsu_res();
	exu_fu_res_if div_res();

	exu_alu alu_u (
		.op_mode(s_alu_op_mode), .op1(s_alu_op1), .op2(s_alu_op2), .tid(s_alu_tid),
		.use_res(s_alu_use_res), .valid(s_alu_valid), .res(alu_res.src),
		.brc_cond_res(m_alu_brc_cond_res), .ls_addr(alu_ls_addr)
	);

	exu_lsu lsu_u (
		.aclk(aclk), .reset(reset), .ls_sel(s_lsu_ls_sel), .ls_type(s_lsu_ls_type),
		.ls_addr(alu_ls_addr), .ls_din(s_lsu_ls_din), .tid(s_lsu_inst_id),
		.req_valid(s_lsu_valid), .req_ready(s_lsu_ready),
		.m_icb_cmd_addr(m_icb_cmd_addr), .m_icb_cmd_read(m_icb_cmd_read),
		.m_icb_cmd_wdata(m_icb_cmd_wdata), .m_icb_cmd_wmask(m_icb_cmd_wmask),
		.m_icb_cmd_valid(m_icb_cmd_valid), .m_icb_cmd_ready(m_icb_cmd_ready),
		.m_icb_rsp_rdata(m_icb_rsp_rdata), .m_icb_rsp_err(m_icb_rsp_err),
		.m_icb_rsp_valid(m_icb_rsp_valid), .m_icb_rsp_ready(m_icb_rsp_ready),
		.res(lsu_res.src), .dbus_timeout(dbus_timeout)
	);

	exu_divider divider_u (
		.aclk(aclk), .reset(reset), .op_a(s_div_op_a), .op_b(s_div_op_b),
		.rem_sel(s_div_rem_sel), .tid(s_div_inst_id), .req_valid(s_div_valid),
		.req_ready(s_div_ready), .res(div_res.src)
	);

	assign fu_res_vld = {div_res.vld, lsu_res.vld, alu_res.vld};
	assign fu_res_tid = {div_res.tid, lsu_res.tid, alu_res.tid};
	assign fu_res_data = {div_res.data, lsu_res.data, alu_res.data}; // lsu gives address on error
	assign fu_res_err = {div_res.err, lsu_res.err, alu_res.err};

endmodule

// ==== exu_divider.sv ====
// iterative signed restoring divider for div and rem
// takes 33-bit sign-extended operands, result pulses 34 cycles after accept
`timescale 1ns/10ps
`include "exu_settings.svh"

module exu_divider (
	input logic aclk,
	input logic reset,
	input logic signed [32:0] op_a, // dividend
	input logic signed [32:0] op_b, // divisor
	input logic rem_sel, // 0 quotient, 1 remainder
	input logic [`EXU_TID_WIDTH-1:0] tid,
	input logic req_valid,
	output logic req_ready,
	exu_fu_res_if.src res
);
	import exu_pkg::*;

	localparam int iter_w = $clog2(`EXU_DIV_ITER + 1);

	div_state_e state;
	logic [iter_w-1:0] cnt;
	logic [32:0] dvd_q; // dividend shifts out, quotient shifts in
	logic [32:0] rem_q;
	logic [32:0] dvs_q;
	logic neg_q; // quotient sign, cleared on divide by zero
	logic neg_r; // remainder follows the dividend
	logic rem_sel_q;
	logic [`EXU_TID_WIDTH-1:0] tid_q;
	logic accept;
	logic last;
	logic [33:0] rem_sh;
	logic [34:0] trial;
	logic [32:0] q_fix;
	logic [32:0] r_fix;

	assign req_ready = state == div_idle;
	assign accept = req_valid & req_ready;
	assign last = cnt == iter_w'(`EXU_DIV_ITER);
	assign rem_sh = {rem_q, dvd_q[32]};
	assign trial = {1'b0, rem_sh} - {2'b00, dvs_q}; // msb set means restore

	always_ff @(posedge aclk) begin
		if (reset) begin
			state <= div_idle;
			cnt <= '0;
		end else begin
			case (state)
				div_idle: if (accept) state <= div_run;
				div_run: if (last) state <= div_done;
				default: state <= div_idle; // done lasts one cycle
			endcase
			if (state == div_run)
				cnt <= cnt + 1'b1;
			else
				cnt <= '0;
		end
	end

	always_ff @(posedge aclk) begin
		if (accept) begin
			dvd_q <= op_a[32] ? -op_a : op_a; // magnitudes only
			dvs_q <= op_b[32] ? -op_b : op_b;
			rem_q <= '0;
			neg_q <= (op_a[32] ^ op_b[32]) & (op_b != 33'sd0);
			neg_r <= op_a[32];
			rem_sel_q <= rem_sel;
			tid_q <= tid;
		end else if ((state == div_run) & ~last) begin
			if (trial[34]) begin
				rem_q <= rem_sh[32:0];
				dvd_q <= {dvd_q[31:0], 1'b0};
			end else begin
				rem_q <= trial[32:0];
				dvd_q <= {dvd_q[31:0], 1'b1};
			end
		end
	end

	assign q_fix = neg_q ? -dvd_q : dvd_q;
	assign r_fix = neg_r ? -rem_q : rem_q;

	assign res.vld = state == div_done;
	assign res.tid = tid_q;
	assign res.data = rem_sel_q ? r_fix[31:0] : q_fix[31:0];
	assign res.err = err_normal;

endmodule

// ==== exu_lsu.sv ====
// single access load/store unit driving the data icb master port
// checks alignment, steers byte lanes and times out a missing response
`timescale 1ns/10ps
`include "exu_settings.svh"

module exu_lsu (
	input logic aclk,
	input logic reset,
	input logic ls_sel, // 0 load, 1 store
	input exu_pkg::ls_type_e ls_type,
	input logic [31:0] ls_addr,
	input logic [31:0] ls_din,
	input logic [`EXU_TID_WIDTH-1:0] tid,
	input logic req_valid,
	output logic req_ready,
	output logic [31:0] m_icb_cmd_addr,
	output logic m_icb_cmd_read,
	output logic [31:0] m_icb_cmd_wdata,
	output logic [3:0] m_icb_cmd_wmask,
	output logic m_icb_cmd_valid,
	input logic m_icb_cmd_ready,
	input logic [31:0] m_icb_rsp_rdata,
	input logic m_icb_rsp_err,
	input logic m_icb_rsp_valid,
	output logic m_icb_rsp_ready,
	exu_fu_res_if.src res,
	output logic dbus_timeout
);
	import exu_pkg::*;

	localparam int to_cnt_w = $clog2(`EXU_DBUS_TIMEOUT_TH + 1);

	lsu_state_e state;
	lsu_state_e state_nxt;
	logic rdy_q; // mirrors state == idle, low right after reset
	logic timeout_q;
	logic [to_cnt_w-1:0] to_cnt;
	logic sel_q;
	ls_type_e type_q;
	logic [31:0] addr_q;
	logic [31:0] din_q;
	logic [`EXU_TID_WIDTH-1:0] tid_q;
	logic [31:0] data_q;
	fu_err_e err_q;
	logic accept;
	logic misalign;
	logic to_expire;
	logic [31:0] rd_sh;
	logic [31:0] ld_ext;
	logic [3:0] wmask;

	assign accept = req_valid & rdy_q;
	assign to_expire = to_cnt == to_cnt_w'(`EXU_DBUS_TIMEOUT_TH - 1);

	always_comb begin
		case (ls_type)
			ls_half, ls_half_u: misalign = ls_addr[0];
			ls_word:            misalign = |ls_addr[1:0];
			default:            misalign = 1'b0; // bytes are always aligned
		endcase
	end

	always_comb begin
		state_nxt = state;
		case (state)
			lsu_idle: begin
				if (accept & misalign)
					state_nxt = lsu_done; // no bus command
				else if (accept)
					state_nxt = lsu_cmd;
			end
			lsu_cmd: if (m_icb_cmd_ready) state_nxt = lsu_rsp;
			lsu_rsp: if (m_icb_rsp_valid | to_expire) state_nxt = lsu_done;
			default: state_nxt = lsu_idle;
		endcase
	end

	always_ff @(posedge aclk) begin
		if (reset) begin
			state <= lsu_idle;
			rdy_q <= 1'b0;
			timeout_q <= 1'b0;
			to_cnt <= '0;
		end else begin
			state <= state_nxt;
			rdy_q <= state_nxt == lsu_idle;
			if ((state == lsu_rsp) & ~m_icb_rsp_valid & to_expire)
				timeout_q <= 1'b1; // sticky until reset
			if (state == lsu_rsp)
				to_cnt <= to_cnt + 1'b1;
			else
				to_cnt <= '0;
		end
	end

	always_ff @(posedge aclk) begin
		if (accept) begin
			sel_q <= ls_sel;
			type_q <= ls_type;
			addr_q <= ls_addr;
			din_q <= ls_din;
			tid_q <= tid;
			data_q <= ls_addr; // kept as result on any error
			if (ls_sel)
				err_q <= err_wt_unaligned;
			else
				err_q <= err_rd_unaligned;
		end else if ((state == lsu_rsp) & m_icb_rsp_valid & ~m_icb_rsp_err) begin
			data_q <= ld_ext;
			err_q <= err_normal;
		end else if ((state == lsu_rsp) & (m_icb_rsp_valid | to_expire)) begin
			if (sel_q)
				err_q <= err_wt_failed;
			else
				err_q <= err_rd_failed;
		end
	end

	// store lanes, data replicated so any lane offset works
	always_comb begin
		case (type_q)
			ls_byte, ls_byte_u: begin
				m_icb_cmd_wdata = {4{din_q[7:0]}};
				wmask = 4'b0001 << addr_q[1:0];
			end
			ls_half, ls_half_u: begin
				m_icb_cmd_wdata = {2{din_q[15:0]}};
				wmask = 4'b0011 << {addr_q[1], 1'b0};
			end
			default: begin
				m_icb_cmd_wdata = din_q;
				wmask = 4'b1111;
			end
		endcase
	end

	// load lane pulled down to bit 0, then extended by type
	assign rd_sh = m_icb_rsp_rdata >> {addr_q[1:0], 3'b000};
	always_comb begin
		case (type_q)
			ls_byte:   ld_ext = {{24{rd_sh[7]}}, rd_sh[7:0]};
			ls_half:   ld_ext = {{16{rd_sh[15]}}, rd_sh[15:0]};
			ls_byte_u: ld_ext = {24'd0, rd_sh[7:0]};
			ls_half_u: ld_ext = {16'd0, rd_sh[15:0]};
			default:   ld_ext = m_icb_rsp_rdata;
		endcase
	end

	assign req_ready = rdy_q;
	assign m_icb_cmd_addr = {addr_q[31:2], 2'b00}; // word aligned bus address
	assign m_icb_cmd_read = ~sel_q;
	assign m_icb_cmd_wmask = sel_q ? wmask : 4'b0000;
	assign m_icb_cmd_valid = state == lsu_cmd;
	assign m_icb_rsp_ready = state == lsu_rsp;
	assign res.vld = state == lsu_done;
	assign res.tid = tid_q;
	assign res.data = data_q;
	assign res.err = err_q;
	assign dbus_timeout = timeout_q;

endmodule

// ==== exu_alu.sv ====
// combinational rv32i alu with branch compare
// op1+op2 is always on ls_addr as the lsu access address
`timescale 1ns/10ps
`include "exu_settings.svh"

module exu_alu (
	input exu_pkg::alu_op_e op_mode,
	input logic [31:0] op1,
	input logic [31:0] op2,
	input logic [`EXU_TID_WIDTH-1:0] tid,
	input logic use_res,
	input logic valid,
	exu_fu_res_if.src res,
	output logic brc_cond_res,
	output logic [31:0] ls_addr
);
	import exu_pkg::*;

	logic [31:0] sum;
	logic [31:0] diff;
	logic [4:0] shamt;
	logic eq;
	logic lt_s;
	logic lt_u;
	logic [31:0] alu_out;

	assign sum = op1 + op2; // shared by add and the access address
	assign diff = op1 - op2;
	assign shamt = op2[4:0];
	assign eq = op1 == op2;
	assign lt_s = $signed(op1) < $signed(op2);
	assign lt_u = op1 < op2;

	always_comb begin
		case (op_mode)
			alu_op_beq:  brc_cond_res = eq;
			alu_op_bne:  brc_cond_res = ~eq;
			alu_op_blt:  brc_cond_res = lt_s;
			alu_op_bge:  brc_cond_res = ~lt_s;
			alu_op_bltu: brc_cond_res = lt_u;
			alu_op_bgeu: brc_cond_res = ~lt_u;
			default:     brc_cond_res = 1'b0; // not a branch
		endcase
	end

	always_comb begin
		case (op_mode)
			alu_op_add:  alu_out = sum;
			alu_op_sub:  alu_out = diff;
			alu_op_sll:  alu_out = op1 << shamt;
			alu_op_slt:  alu_out = {31'd0, lt_s};
			alu_op_sltu: alu_out = {31'd0, lt_u};
			alu_op_xor:  alu_out = op1 ^ op2;
			alu_op_srl:  alu_out = op1 >> shamt;
			alu_op_sra:  alu_out = $signed(op1) >>> shamt; // arithmetic, keeps sign
			alu_op_or:   alu_out = op1 | op2;
			alu_op_and:  alu_out = op1 & op2;
			default:     alu_out = {31'd0, brc_cond_res}; // branches return the compare
		endcase
	end

	assign ls_addr = sum;
	assign res.vld = valid & use_res; // same cycle, no register
	assign res.tid = tid;
	assign res.data = alu_out;
	assign res.err = err_normal;

endmodule

// ==== exu_fu_res_if.sv ====
// result return bundle of one execution unit
// the unit drives it through src, the top level reads it through dst
`timescale 1ns/10ps
`include "exu_settings.svh"

interface exu_fu_res_if;
	import exu_pkg::*;

	logic vld; // one cycle pulse, never stalled
	logic [`EXU_TID_WIDTH-1:0] tid; // instruction id of the result
	logic [31:0] data; // result, or access address on an lsu error
	fu_err_e err;

	modport src (output vld, output tid, output data, output err);
	modport dst (input vld, input tid, input data, input err);

endinterface

// ==== exu_pkg.sv ====
// opcodes, access types, error codes and fsm states of the execution units
// imported by the units, the testbench and the bound assertions
package exu_pkg;

	typedef enum logic [3:0] {
		alu_op_add  = 4'd0,
		alu_op_sub  = 4'd1,
		alu_op_sll  = 4'd2,
		alu_op_slt  = 4'd3,
		alu_op_sltu = 4'd4,
		alu_op_xor  = 4'd5,
		alu_op_srl  = 4'd6,
		alu_op_sra  = 4'd7,
		alu_op_or   = 4'd8,
		alu_op_and  = 4'd9,
		alu_op_beq  = 4'd10, // branch compares from here on
		alu_op_bne  = 4'd11,
		alu_op_blt  = 4'd12,
		alu_op_bge  = 4'd13,
		alu_op_bltu = 4'd14,
		alu_op_bgeu = 4'd15
	} alu_op_e;

	// bit 2 marks the unsigned loads
	typedef enum logic [2:0] {
		ls_byte   = 3'b000,
		ls_half   = 3'b001,
		ls_word   = 3'b010,
		ls_byte_u = 3'b100,
		ls_half_u = 3'b101
	} ls_type_e;

	typedef enum logic [2:0] {
		err_normal       = 3'd0,
		err_rd_unaligned = 3'd1,
		err_wt_unaligned = 3'd2,
		err_rd_failed    = 3'd3, // bus error or timeout on a load
		err_wt_failed    = 3'd4  // bus error or timeout on a store
	} fu_err_e;

	typedef enum logic [1:0] {lsu_idle, lsu_cmd, lsu_rsp, lsu_done} lsu_state_e;

	typedef enum logic [1:0] {div_idle, div_run, div_done} div_state_e;

endpackage

// ==== exu_settings.svh ====
// widths and thresholds shared by the execution units and the testbench
// pulled in with `include wherever one of these values is needed
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// instruction id width on every result bus
`define EXU_TID_WIDTH 8
// cycles the lsu waits for an icb response
`define EXU_DBUS_TIMEOUT_TH 16
// restoring steps per divide, one per quotient bit
`define EXU_DIV_ITER 33

`endif
